// File: list.f
design/awg_pkg.sv
design/awg_control.sv
design/awg_channel.sv
design/awg_playback.sv
design/awg_top.sv
tests/awg_props.sv
tests/awg_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT      ?= --lint-only --timing -Wall
TOP       ?= awg_tb
FILELIST  ?= list.f
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: tests/awg_tb.sv
//////////////////////////////
// testbench for the waveform generator top level
// loads random waveforms, plays bursts and checks every output sample
// against a model built from the frame, burst and trigger rules
//////////////////////////////

module awg_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import awg_pkg::*;

  // negedges from driving start to the first sample on dac_data:
  // control register, playback FSM, then 4 cycles of read latency
  localparam int START_DELAY = 7;
  // stop reaches the outputs 6 cycles after it is driven
  localparam int STOP_DELAY = 6;
  localparam int WATCHDOG_CYCLES = 2000;
  localparam int NO_STOP = 32'h3fff_ffff;

  logic dac_clk = 1'b0;
  logic dac_reset = 1'b1;
  logic cfg_trig_valid = 1'b0;
  trig_mode_e [CHANNELS-1:0] cfg_trig_mode = '{default: TRIG_NONE};
  logic cfg_burst_valid = 1'b0;
  burst_t [CHANNELS-1:0] cfg_burst_count = '0;
  logic load_start = 1'b0;
  addr_t [CHANNELS-1:0] load_frame_last = '0;
  logic wave_valid = 1'b0;
  sample_t wave_sample = '0;
  logic start = 1'b0;
  logic stop = 1'b0;
  sample_t [CHANNELS-1:0] dac_data;
  logic dac_valid;
  logic [CHANNELS-1:0] dac_trigger;
  logic burst_done;
  logic config_ready;
  logic wave_ready;

  // model of the loaded buffers and the playback config
  sample_t model [CHANNELS][64];
  int frame_len [CHANNELS];
  int burst_cnt [CHANNELS];
  trig_mode_e mode [CHANNELS];
  logic [31:0] rng = 32'heae0b3b5;

  // shared between stimulus and the compare process
  bit cmp_busy = 0;
  bit armed = 0;
  bit seen_valid = 0;
  int arm_cnt = 0;
  int k = 0;
  int cmp_len = 0;
  int stop_k = NO_STOP;
  int done_cnt = 0;

  awg_top uut (.*);

  always #50 dac_clk = ~dac_clk;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected {trigger, sample} of one channel at output index k
  function automatic logic [SAMPLE_WIDTH:0] ref_output(int ch, int idx);
    int len;
    int pos;
    logic trig;
    len = frame_len[ch] * burst_cnt[ch];
    if (idx >= len) begin
      return '0;
    end
    pos = idx % frame_len[ch];
    trig = ((mode[ch] == TRIG_FRAME) && (pos == 0)) || ((mode[ch] == TRIG_BURST) && (idx == 0));
    return {trig, model[ch][pos]};
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge dac_clk);
    #5;
  endtask

  //////////////////////////////
  // compare process
  //////////////////////////////

  always @(negedge dac_clk) begin
    logic [SAMPLE_WIDTH:0] expected;
    if (cmp_busy) begin
      if (armed) begin
        arm_cnt++;
        // first burst lines up on dac_valid, later ones on the start
        if (seen_valid ? (arm_cnt == START_DELAY) : dac_valid) begin
          check_value("start latency", arm_cnt, START_DELAY);
          armed = 0;
          seen_valid = 1;
          k = 0;
        end
      end
      if (!armed) begin
        for (int ch = 0; ch < CHANNELS; ch++) begin
          // outputs are undefined while the stop travels through
          if ((k < stop_k) || (k >= stop_k + STOP_DELAY)) begin
            expected = (k >= stop_k) ? '0 : ref_output(ch, k);
            check_value($sformatf("dac_data[%0d]", ch), dac_data[ch],
                        expected[SAMPLE_WIDTH-1:0]);
            check_value($sformatf("dac_trigger[%0d]", ch), dac_trigger[ch],
                        expected[SAMPLE_WIDTH]);
          end
        end
        check_value("dac_valid", dac_valid, 1);
        if (burst_done) begin
          done_cnt++;
        end
        k++;
        if (k == cmp_len) begin
          cmp_busy = 0;
        end
      end
    end else if (!seen_valid) begin
      check_value("dac_valid", dac_valid, 0);
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic configure(trig_mode_e m0, trig_mode_e m1, int c0, int c1);
    cfg_trig_mode = {m1, m0};
    cfg_burst_count = {burst_t'(c1), burst_t'(c0)};
    cfg_trig_valid = 1'b1;
    cfg_burst_valid = 1'b1;
    mode[0] = m0;
    mode[1] = m1;
    burst_cnt[0] = c0;
    burst_cnt[1] = c1;
    next_cycle();
    cfg_trig_valid = 1'b0;
    cfg_burst_valid = 1'b0;
  endtask

  // poke_start drives a start halfway through, which must be ignored
  task automatic load_wave(int f0, int f1, bit poke_start);
    int total;
    int got;
    int ch;
    int addr;
    frame_len[0] = f0 + 1;
    frame_len[1] = f1 + 1;
    total = frame_len[0] + frame_len[1];
    got = 0;
    ch = 0;
    addr = 0;
    load_frame_last = {addr_t'(f1), addr_t'(f0)};
    load_start = 1'b1;
    next_cycle();
    load_start = 1'b0;
    while (got < total) begin
      check_value("config_ready", config_ready, 0);
      check_value("wave_ready", wave_ready, 1);
      rng = xorshift(rng);
      wave_valid = (rng[3:0] != 4'h0);
      wave_sample = rng[31:16];
      start = poke_start && (got == total / 2);
      if (wave_valid) begin
        model[ch][addr] = wave_sample;
        got++;
        addr++;
        if (addr == frame_len[ch]) begin
          addr = 0;
          ch++;
        end
      end
      next_cycle();
    end
    wave_valid = 1'b0;
    start = 1'b0;
    check_value("wave_ready", wave_ready, 0);
    check_value("config_ready", config_ready, 0);
  endtask

  // a negative stop_after plays the whole burst
  task automatic play_burst(int len, int stop_after, int exp_done);
    armed = 1;
    arm_cnt = 0;
    cmp_len = len;
    stop_k = NO_STOP;
    done_cnt = 0;
    cmp_busy = 1;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    if (stop_after >= 0) begin
      while (armed || (k < stop_after)) begin
        next_cycle();
      end
      stop = 1'b1;
      stop_k = k;
      next_cycle();
      stop = 1'b0;
    end
    while (cmp_busy) begin
      next_cycle();
    end
    check_value("burst_done pulses", done_cnt, exp_done);
    check_value("config_ready", config_ready, 1);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    repeat (8) @(posedge dac_clk);
    #5;
    dac_reset = 1'b0;
    check_value("dac_valid", dac_valid, 0);
    check_value("dac_trigger", dac_trigger, 0);
    check_value("burst_done", burst_done, 0);
    check_value("config_ready", config_ready, 1);
    check_value("wave_ready", wave_ready, 0);

    // different frames and counts, frame and burst triggers
    configure(TRIG_FRAME, TRIG_BURST, 3, 2);
    load_wave(9, 20, 1'b1);
    repeat (10) next_cycle();
    play_burst(52, -1, 1);

    // replay the same buffers with new triggers and counts
    configure(TRIG_NONE, TRIG_FRAME, 2, 1);
    play_burst(31, -1, 1);

    // long burst cut short by a stop
    configure(TRIG_FRAME, TRIG_FRAME, 4, 4);
    load_wave(63, 63, 1'b0);
    play_burst(60, 40, 0);

    $display("Simulation completed successfully");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge dac_clk);
    $display("The run took too long and was stopped by the watchdog");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// File: tests/awg_props.sv
//////////////////////////////
// concurrent checks on the load control block
// attached to every control instance through bind
//////////////////////////////

module awg_props (
  input logic dac_clk,
  input logic dac_reset,
  input logic config_ready,
  input logic wave_ready,
  input logic wave_accept,
  input logic last_word,
  input logic all_done
);
  timeunit 1ns;
  timeprecision 1ps;

  // config and wave loading are exclusive phases
  ready_exclusive: assert property (@(posedge dac_clk) disable iff (dac_reset)
    !(config_ready && wave_ready))
    else $error("config_ready and wave_ready are both high");

  // burst_done is a single cycle pulse
  done_pulse: assert property (@(posedge dac_clk) disable iff (dac_reset)
    all_done |=> !all_done)
    else $error("burst_done lasted more than one cycle");

  // last word of the last channel ends loading
  load_end: assert property (@(posedge dac_clk) disable iff (dac_reset)
    (wave_accept && last_word) |=> !wave_ready)
    else $error("wave_ready stayed high after the final word");

endmodule

bind awg_control awg_props u_props (
  .dac_clk      (dac_clk),
  .dac_reset    (dac_reset),
  .config_ready (config_ready),
  .wave_ready   (wave_ready),
  .wave_accept  (wave_accept),
  .last_word    (last_word),
  .all_done     (all_done)
);

// File: design/awg_top.sv
//////////////////////////////
// waveform generator top level
// load control, one block per channel and the DAC output stage
//////////////////////////////

module awg_top (
  input  logic                                         dac_clk,
  input  logic                                         dac_reset,
  input  logic                                         cfg_trig_valid,
  input  awg_pkg::trig_mode_e [awg_pkg::CHANNELS-1:0] cfg_trig_mode,
  input  logic                                         cfg_burst_valid,
  input  awg_pkg::burst_t [awg_pkg::CHANNELS-1:0]     cfg_burst_count,
  input  logic                                         load_start,
  input  awg_pkg::addr_t [awg_pkg::CHANNELS-1:0]      load_frame_last,
  input  logic                                         wave_valid,
  input  awg_pkg::sample_t                             wave_sample,
  input  logic                                         start,
  input  logic                                         stop,
  output awg_pkg::sample_t [awg_pkg::CHANNELS-1:0]    dac_data,
  output logic                                         dac_valid,
  output logic [awg_pkg::CHANNELS-1:0]                 dac_trigger,
  output logic                                         burst_done,
  output logic                                         config_ready,
  output logic                                         wave_ready
);
  import awg_pkg::*;

  chan_cfg_t [CHANNELS-1:0] cfg;
  wr_req_t wr_req;
  logic play_start;
  logic play_stop;
  logic play_active;
  sample_t [CHANNELS-1:0] chan_sample;
  logic [CHANNELS-1:0] chan_trigger;
  logic [CHANNELS-1:0] chan_done;

  // burst_done doubles as the end-of-burst return to the load FSM
  awg_control u_control (
    .dac_clk         (dac_clk),
    .dac_reset       (dac_reset),
    .cfg_trig_valid  (cfg_trig_valid),
    .cfg_trig_mode   (cfg_trig_mode),
    .cfg_burst_valid (cfg_burst_valid),
    .cfg_burst_count (cfg_burst_count),
    .load_start      (load_start),
    .load_frame_last (load_frame_last),
    .wave_valid      (wave_valid),
    .wave_sample     (wave_sample),
    .start           (start),
    .stop            (stop),
    .all_done        (burst_done),
    .cfg             (cfg),
    .wr_req          (wr_req),
    .play_start      (play_start),
    .play_stop       (play_stop),
    .config_ready    (config_ready),
    .wave_ready      (wave_ready)
  );

  for (genvar i = 0; i < CHANNELS; i++) begin : g_chan
    localparam chan_t CHAN = chan_t'(i);

    // each buffer only sees writes addressed to its own index
    wr_req_t chan_wr;
    assign chan_wr = '{
      en:     wr_req.en && (wr_req.chan == CHAN),
      chan:   wr_req.chan,
      addr:   wr_req.addr,
      sample: wr_req.sample
    };

    awg_channel u_channel (
      .dac_clk      (dac_clk),
      .dac_reset    (dac_reset),
      .cfg          (cfg[i]),
      .wr_req       (chan_wr),
      .play_active  (play_active),
      .chan_sample  (chan_sample[i]),
      .chan_trigger (chan_trigger[i]),
      .chan_done    (chan_done[i])
    );
  end

  awg_playback u_playback (
    .dac_clk      (dac_clk),
    .dac_reset    (dac_reset),
    .play_start   (play_start),
    .play_stop    (play_stop),
    .chan_sample  (chan_sample),
    .chan_trigger (chan_trigger),
    .chan_done    (chan_done),
    .play_active  (play_active),
    .all_done     (burst_done),
    .dac_data     (dac_data),
    .dac_valid    (dac_valid),
    .dac_trigger  (dac_trigger)
  );

endmodule

// File: design/awg_playback.sv
//////////////////////////////
// playback control and DAC output stage
// zeroes idle or finished channels, registers data, valid and triggers
//////////////////////////////

module awg_playback (
  input  logic                                      dac_clk,
  input  logic                                      dac_reset,
  input  logic                                      play_start,
  input  logic                                      play_stop,
  input  awg_pkg::sample_t [awg_pkg::CHANNELS-1:0] chan_sample,
  input  logic [awg_pkg::CHANNELS-1:0]              chan_trigger,
  input  logic [awg_pkg::CHANNELS-1:0]              chan_done,
  output logic                                      play_active,
  output logic                                      all_done,
  output awg_pkg::sample_t [awg_pkg::CHANNELS-1:0] dac_data,
  output logic                                      dac_valid,
  output logic [awg_pkg::CHANNELS-1:0]              dac_trigger
);
  import awg_pkg::*;

  typedef enum logic {
    IDLE,
    ACTIVE
  } play_state_e;

  play_state_e state;

  // set by the first start after reset, never cleared
  logic started;
  logic [2:0] valid_pipe;

  // play_active delayed to the read data
  logic [1:0] active_pipe;

  logic [CHANNELS-1:0] zero_sel;
  sample_t [CHANNELS-1:0] sel_data;
  logic [CHANNELS-1:0] sel_trigger;

  assign play_active = (state == ACTIVE);

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      state <= IDLE;
    end else begin
      unique case (state)
        IDLE: begin
          if (play_start) begin
            state <= ACTIVE;
          end
        end
        ACTIVE: begin
          if (play_stop || all_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // valid, done, pipelines
  //////////////////////////////

  // valid rises with the first sample, 4 cycles behind started
  // all_done fires once, and only for a burst of the current run
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      started     <= 1'b0;
      valid_pipe  <= '0;
      dac_valid   <= 1'b0;
      active_pipe <= '0;
      all_done    <= 1'b0;
    end else begin
      if (play_start) begin
        started <= 1'b1;
      end
      valid_pipe  <= {valid_pipe[1:0], started};
      dac_valid   <= valid_pipe[2];
      active_pipe <= {active_pipe[0], play_active};
      all_done    <= play_active && active_pipe[1] && (&chan_done) && !all_done;
    end
  end

  //////////////////////////////
  // output stage
  //////////////////////////////

  assign zero_sel = chan_done | {CHANNELS{!active_pipe[1]}};

  // zero-select register, then output register
  always_ff @(posedge dac_clk) begin
    for (int i = 0; i < CHANNELS; i++) begin
      sel_data[i] <= zero_sel[i] ? '0 : chan_sample[i];
    end
    dac_data <= sel_data;
  end

  // triggers follow the same two stages, masked like the data
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      sel_trigger <= '0;
      dac_trigger <= '0;
    end else begin
      sel_trigger <= chan_trigger & ~zero_sel;
      dac_trigger <= sel_trigger;
    end
  end

endmodule

// File: design/awg_channel.sv
//////////////////////////////
// one output channel: sample buffer, read pointer and burst bookkeeping
// read data, done flag and trigger leave aligned to the same cycle
//////////////////////////////

module awg_channel (
  input  logic                dac_clk,
  input  logic                dac_reset,
  input  awg_pkg::chan_cfg_t  cfg,
  input  awg_pkg::wr_req_t    wr_req,
  input  logic                play_active,
  output awg_pkg::sample_t    chan_sample,
  output logic                chan_trigger,
  output logic                chan_done
);
  import awg_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  // waveform storage
  sample_t mem [DEPTH];

  // first buffer read register, chan_sample is the second
  sample_t rd_data;

  addr_t  rd_addr;
  burst_t frame_cnt;

  logic frame_end;
  logic burst_end;
  logic trig_hit;

  // sticky once the last frame has been read out
  logic done_q;
  logic [1:0] done_pipe;

  // trigger for the address presented one cycle earlier
  logic trig_q;

  //////////////////////////////
  // buffer
  //////////////////////////////

  // requests for the other channel arrive with en low
  always_ff @(posedge dac_clk) begin
    if (wr_req.en) begin
      mem[wr_req.addr] <= wr_req.sample;
    end
  end

  // two read registers
  always_ff @(posedge dac_clk) begin
    rd_data     <= mem[rd_addr];
    chan_sample <= rd_data;
  end

  //////////////////////////////
  // read pointer and frame count
  //////////////////////////////

  assign frame_end = (rd_addr == cfg.frame_last);
  assign burst_end = frame_end && (frame_cnt == cfg.burst_last);

  // trigger only at the frame start, never after the burst
  always_comb begin
    trig_hit = 1'b0;
    if (!done_q && (rd_addr == '0)) begin
      if (cfg.trig_mode == TRIG_FRAME) begin
        trig_hit = 1'b1;
      end
      if ((cfg.trig_mode == TRIG_BURST) && (frame_cnt == '0)) begin
        trig_hit = 1'b1;
      end
    end
  end

  // address 0 sits ready while idle, so the first active cycle reads word 0
  always_ff @(posedge dac_clk) begin
    if (dac_reset || !play_active) begin
      rd_addr   <= '0;
      frame_cnt <= '0;
      done_q    <= 1'b0;
      trig_q    <= 1'b0;
    end else begin
      if (frame_end) begin
        rd_addr <= '0;
        // wraps after the burst, outputs are zeroed from then on
        if (frame_cnt == cfg.burst_last) begin
          frame_cnt <= '0;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
      if (burst_end) begin
        done_q <= 1'b1;
      end
      trig_q <= trig_hit;
    end
  end

  //////////////////////////////
  // alignment to read data
  //////////////////////////////

  // done_q marks the address it came with, so it needs both read delays
  // trig_q already carries one of them
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      done_pipe    <= '0;
      chan_trigger <= 1'b0;
    end else begin
      done_pipe    <= {done_pipe[0], done_q};
      chan_trigger <= trig_q;
    end
  end

  assign chan_done = done_pipe[1];

endmodule

// File: design/awg_control.sv
//////////////////////////////
// configuration registers and waveform load sequencing
// sorts incoming samples into the channel buffers one channel after the other
// and gates start and stop before they reach the playback block
//////////////////////////////

module awg_control (
  input  logic                                         dac_clk,
  input  logic                                         dac_reset,
  input  logic                                         cfg_trig_valid,
  input  awg_pkg::trig_mode_e [awg_pkg::CHANNELS-1:0] cfg_trig_mode,
  input  logic                                         cfg_burst_valid,
  input  awg_pkg::burst_t [awg_pkg::CHANNELS-1:0]     cfg_burst_count,
  input  logic                                         load_start,
  input  awg_pkg::addr_t [awg_pkg::CHANNELS-1:0]      load_frame_last,
  input  logic                                         wave_valid,
  input  awg_pkg::sample_t                             wave_sample,
  input  logic                                         start,
  input  logic                                         stop,
  input  logic                                         all_done,
  output awg_pkg::chan_cfg_t [awg_pkg::CHANNELS-1:0]  cfg,
  output awg_pkg::wr_req_t                             wr_req,
  output logic                                         play_start,
  output logic                                         play_stop,
  output logic                                         config_ready,
  output logic                                         wave_ready
);
  import awg_pkg::*;

  // IDLE takes config, LOADING takes samples, HOLD waits for the burst to end
  typedef enum logic [1:0] {
    IDLE,
    LOADING,
    HOLD
  } load_state_e;

  load_state_e state;

  // write pointer into the buffers
  chan_t wr_chan;
  addr_t wr_addr;

  logic wave_accept;
  logic chan_full;
  logic last_word;

  assign config_ready = (state == IDLE);
  assign wave_ready   = (state == LOADING);
  assign wave_accept  = wave_valid && wave_ready;

  // current channel gets its final word at its frame_last
  assign chan_full = (wr_addr == cfg[wr_chan].frame_last);
  assign last_word = chan_full && (wr_chan == chan_t'(CHANNELS - 1));

  //////////////////////////////
  // configuration registers
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      cfg <= '0;
    end else if (config_ready) begin
      for (int i = 0; i < CHANNELS; i++) begin
        if (cfg_trig_valid) begin
          cfg[i].trig_mode <= cfg_trig_mode[i];
        end
        // frame counter compares against count minus one
        if (cfg_burst_valid) begin
          cfg[i].burst_last <= cfg_burst_count[i] - 1'b1;
        end
        if (load_start) begin
          cfg[i].frame_last <= load_frame_last[i];
        end
      end
    end
  end

  //////////////////////////////
  // load state machine
  //////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      state <= IDLE;
    end else begin
      unique case (state)
        IDLE: begin
          if (load_start) begin
            state <= LOADING;
          end
        end
        LOADING: begin
          // last channel full, stop taking samples
          if (wave_accept && last_word) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (stop || all_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // address counts up to frame_last, then the next channel starts at 0
  always_ff @(posedge dac_clk) begin
    if (dac_reset || (state != LOADING)) begin
      wr_chan <= '0;
      wr_addr <= '0;
    end else if (wave_accept) begin
      if (chan_full) begin
        wr_addr <= '0;
        if (last_word) begin
          wr_chan <= '0;
        end else begin
          wr_chan <= wr_chan + 1'b1;
        end
      end else begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  // registered write request, payload just follows the pointer
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      wr_req.en <= 1'b0;
    end else begin
      wr_req.en <= wave_accept;
    end
    wr_req.chan   <= wr_chan;
    wr_req.addr   <= wr_addr;
    wr_req.sample <= wave_sample;
  end

  //////////////////////////////
  // start / stop
  //////////////////////////////

  // no playback start while the buffers are being written
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      play_start <= 1'b0;
      play_stop  <= 1'b0;
    end else begin
      play_start <= start && (state != LOADING);
      play_stop  <= stop;
    end
  end

endmodule

// File: design/awg_pkg.sv
//////////////////////////////
// shared sizes, vector types and packed structs for the waveform generator
// every design file imports what it needs from here
//////////////////////////////

package awg_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // number of DAC output channels
  localparam int CHANNELS = 2;
  // one DAC sample
  localparam int SAMPLE_WIDTH = 16;
  // buffer address, 64 words per channel
  localparam int ADDR_WIDTH = 6;
  // frames per burst, stored minus one
  localparam int BURST_WIDTH = 8;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  // also used for a frame's last address
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [BURST_WIDTH-1:0] burst_t;
  typedef logic [$clog2(CHANNELS)-1:0] chan_t;

  // trigger behaviour per channel
  typedef enum logic [1:0] {
    TRIG_NONE  = 2'd0,
    TRIG_BURST = 2'd1,
    TRIG_FRAME = 2'd2
  } trig_mode_e;

  // playback config of one channel, 16 bits
  typedef struct packed {
    addr_t      frame_last;
    trig_mode_e trig_mode;
    burst_t     burst_last;
  } chan_cfg_t;

  // one buffer write, broadcast to all channels, 24 bits
  typedef struct packed {
    logic    en;
    chan_t   chan;
    addr_t   addr;
    sample_t sample;
  } wr_req_t;

endpackage
